// ==== logic/fetch_config.svh ====
// Fetch front end build parameters.
// Queue depth must be a power of two and at least 4.
// Reset PCs are sized to the 32-bit address width; resize them if it changes.

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// datapath widths
`define FETCH_ADDR_WIDTH  32
`define FETCH_INST_WIDTH  32

// fetch queue entries, also sets the issue window
`define FETCH_QUEUE_DEPTH 8

// start addresses of the two threads
`define FETCH_RESET_PC0   32'h0000_1000
`define FETCH_RESET_PC1   32'h0000_8000

`endif

// ==== logic/fetch_types_pkg.sv ====
// Types shared along the fetch pipeline.
// Entry layout follows the widths in the config header.

`include "fetch_config.svh"

package fetch_types_pkg;

	////////////////////////////////////////////////////////////////////////////
	// slot arbitration

	// owner of the next fetch slot; PROGRAM_START is the idle cycle after reset
	typedef enum logic [1:0]
	{
		PROGRAM_START,
		THREAD0_SLOT,
		THREAD1_SLOT
	} thread_state_e;

	////////////////////////////////////////////////////////////////////////////
	// queue payload

	// one fetched instruction with its origin
	typedef struct packed
	{
		logic                         thread;  // 0 or 1
		logic [`FETCH_ADDR_WIDTH-1:0] pc;
		logic [`FETCH_INST_WIDTH-1:0] inst;
	} fetch_entry_t;

endpackage

// ==== logic/isa_pkg.sv ====
// Instruction encoding seen by predecode.
// Opcode sits in the top three bits of a 32-bit word.

package isa_pkg;

	// lowest bit of the opcode field
	localparam int OPCODE_LSB = 29;

	// all eight codes are named, so every word decodes
	typedef enum logic [2:0]
	{
		OP_ALU     = 3'd0,
		OP_ALU_IMM = 3'd1,
		OP_LOAD    = 3'd2,
		OP_STORE   = 3'd3,
		OP_BRANCH  = 3'd4,
		OP_JUMP    = 3'd5,
		OP_SYSTEM  = 3'd6,
		OP_NOP     = 3'd7
	} opcode_e;

	// coarse class handed to decode
	typedef enum logic [1:0]
	{
		CLASS_COMPUTE = 2'd0,
		CLASS_MEMORY  = 2'd1,
		CLASS_CONTROL = 2'd2,
		CLASS_OTHER   = 2'd3
	} inst_class_e;

endpackage

// ==== logic/fetch_bus_if.sv ====
// Valid/ready link carrying fetch entries.
// Transfer on a rising edge with valid and ready high; once valid rises,
// valid and entry hold until the transfer.

interface fetch_bus_if import fetch_types_pkg::*; ();

	logic         valid;
	logic         ready;
	fetch_entry_t entry;

	modport producer
	(
		output valid,
		output entry,
		input  ready
	);

	modport consumer
	(
		input  valid,
		input  entry,
		output ready
	);

endinterface

// ==== logic/thread_pc_unit.sv ====
// Two-thread PC holder and slot arbiter.
// Memory answers every request exactly one cycle later, so at most one
// request is outstanding. Responses are pushed without checking ready;
// space_ok must reserve room for the one in flight.

`include "fetch_config.svh"

module thread_pc_unit import fetch_types_pkg::*;
(
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         two_threads,
	input  logic [1:0]                   thread_stall,
	input  logic                         redirect_valid,
	input  logic                         redirect_thread,
	input  logic [`FETCH_ADDR_WIDTH-1:0] redirect_pc,
	output logic                         imem_req,
	output logic [`FETCH_ADDR_WIDTH-1:0] imem_addr,
	input  logic [`FETCH_INST_WIDTH-1:0] imem_data,
	input  logic                         imem_valid,
	input  logic                         space_ok,
	fetch_bus_if.producer                out
);

	localparam int ADDR_W = `FETCH_ADDR_WIDTH;

	logic [ADDR_W-1:0] pc [2];       // per-thread next fetch address
	thread_state_e     state;
	thread_state_e     next_state;
	logic              owner;        // slot owner by turn
	logic              sel;          // thread actually using the slot
	logic              issue;
	logic              pend_thread;  // tag of the outstanding request
	logic [ADDR_W-1:0] pend_pc;

	////////////////////////////////////////////////////////////////////////////
	// slot choice and issue

	always_comb
	begin
		owner = (state == THREAD1_SLOT);
		if (!two_threads)
			sel = 1'b0;
		else if (thread_stall[owner] && !thread_stall[!owner])
			sel = !owner;  // stalled owner hands the slot over
		else
			sel = owner;
	end

	assign issue     = (state != PROGRAM_START) && space_ok && !thread_stall[sel];
	assign imem_req  = issue;
	assign imem_addr = pc[sel];

	// turn passes to the thread that did not just fetch
	always_comb
	begin
		case (state)
			PROGRAM_START:
				next_state = THREAD0_SLOT;
			default:
			begin
				if (!two_threads)
					next_state = THREAD0_SLOT;
				else if (issue)
					next_state = sel ? THREAD0_SLOT : THREAD1_SLOT;
				else
					next_state = state;  // keep the turn while blocked
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// PC and state registers

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= PROGRAM_START;
			pc[0] <= `FETCH_RESET_PC0;
			pc[1] <= `FETCH_RESET_PC1;
		end
		else
		begin
			state <= next_state;
			for (int t = 0; t < 2; t++)
			begin
				if (redirect_valid && (redirect_thread == t[0]))
					pc[t] <= redirect_pc;  // redirect beats advance
				else if (issue && (sel == t[0]))
					pc[t] <= pc[t] + ADDR_W'(4);
			end
		end
	end

	// origin of the request now at the memory
	always_ff @(posedge clock)
	begin
		if (issue)
		begin
			pend_thread <= sel;
			pend_pc     <= pc[sel];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// response to queue

	assign out.valid = imem_valid;

	always_comb
	begin
		out.entry = '{thread: pend_thread, pc: pend_pc, inst: imem_data};
	end

endmodule

// ==== logic/fetch_queue.sv ====
// Circular FIFO of fetch entries.
// Depth must be a power of two so the pointers wrap on their own.
// space_ok leaves two free slots: one for this cycle's request,
// one for the response already on its way.

`include "fetch_config.svh"

module fetch_queue import fetch_types_pkg::*;
(
	input  logic          clock,
	input  logic          reset,
	fetch_bus_if.consumer in,
	fetch_bus_if.producer out,
	output logic          space_ok
);

	localparam int DEPTH = `FETCH_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	localparam logic [PTR_W:0] FULL_COUNT  = (PTR_W+1)'(DEPTH);
	localparam logic [PTR_W:0] SPACE_LIMIT = (PTR_W+1)'(DEPTH - 2);

	fetch_entry_t     mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             push;
	logic             pop;

	////////////////////////////////////////////////////////////////////////////
	// handshakes

	assign in.ready  = (count != FULL_COUNT);
	assign out.valid = (count != '0);
	assign out.entry = mem[rd_ptr];  // head entry

	assign push = in.valid && in.ready;
	assign pop  = out.valid && out.ready;

	assign space_ok = (count <= SPACE_LIMIT);

	////////////////////////////////////////////////////////////////////////////
	// storage and pointers

	always_ff @(posedge clock)
	begin
		if (push)
			mem[wr_ptr] <= in.entry;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;

			// occupancy moves only when exactly one side fires
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== logic/predecode_unit.sv ====
// One-entry output stage with opcode classification.
// Reloads in the same cycle its entry is taken, so it runs at full rate.

`include "fetch_config.svh"

module predecode_unit import fetch_types_pkg::*, isa_pkg::*;
(
	input  logic                         clock,
	input  logic                         reset,
	fetch_bus_if.consumer                in,
	output logic                         out_valid,
	output logic                         out_thread,
	output logic [`FETCH_ADDR_WIDTH-1:0] out_pc,
	output logic [`FETCH_INST_WIDTH-1:0] out_inst,
	output inst_class_e                  out_class,
	input  logic                         out_ready
);

	fetch_entry_t entry_q;
	inst_class_e  class_q;
	logic         valid_q;

	// opcode to class mapping
	function automatic inst_class_e opcode_class(input logic [`FETCH_INST_WIDTH-1:0] inst);
		opcode_e op;
		op = opcode_e'(inst[OPCODE_LSB +: $bits(opcode_e)]);
		case (op)
			OP_ALU, OP_ALU_IMM: opcode_class = CLASS_COMPUTE;
			OP_LOAD, OP_STORE:  opcode_class = CLASS_MEMORY;
			OP_BRANCH, OP_JUMP: opcode_class = CLASS_CONTROL;
			default:            opcode_class = CLASS_OTHER;  // system, nop
		endcase
	endfunction

	// take a new entry when empty or when the held one leaves
	assign in.ready = !valid_q || out_ready;

	always_ff @(posedge clock)
	begin
		if (reset)
			valid_q <= 1'b0;
		else if (in.ready)
			valid_q <= in.valid;
	end

	always_ff @(posedge clock)
	begin
		if (in.valid && in.ready)
		begin
			entry_q <= in.entry;
			class_q <= opcode_class(in.entry.inst);
		end
	end

	assign out_valid  = valid_q;
	assign out_thread = entry_q.thread;
	assign out_pc     = entry_q.pc;
	assign out_inst   = entry_q.inst;
	assign out_class  = class_q;

endmodule

// ==== logic/fetch_top.sv ====
// Fetch front end top level.
// Instruction memory must answer each request exactly one cycle later;
// there is no memory-side ready. Decode port is valid/ready.

`include "fetch_config.svh"

module fetch_top import isa_pkg::*;
(
	input  logic                         clock,
	input  logic                         reset,

	// instruction memory
	output logic                         imem_req,
	output logic [`FETCH_ADDR_WIDTH-1:0] imem_addr,
	input  logic [`FETCH_INST_WIDTH-1:0] imem_data,
	input  logic                         imem_valid,

	// thread control
	input  logic                         two_threads,
	input  logic [1:0]                   thread_stall,
	input  logic                         redirect_valid,
	input  logic                         redirect_thread,
	input  logic [`FETCH_ADDR_WIDTH-1:0] redirect_pc,

	// decode side
	output logic                         out_valid,
	output logic                         out_thread,
	output logic [`FETCH_ADDR_WIDTH-1:0] out_pc,
	output logic [`FETCH_INST_WIDTH-1:0] out_inst,
	output inst_class_e                  out_class,
	input  logic                         out_ready
);

	fetch_bus_if fetch_to_queue ();
	fetch_bus_if queue_to_decode ();

	logic space_ok;  // queue can absorb a new request plus one in flight

	////////////////////////////////////////////////////////////////////////////
	// producer, buffer, consumer

	thread_pc_unit u_thread_pc_unit
	(
		.clock           (clock),
		.reset           (reset),
		.two_threads     (two_threads),
		.thread_stall    (thread_stall),
		.redirect_valid  (redirect_valid),
		.redirect_thread (redirect_thread),
		.redirect_pc     (redirect_pc),
		.imem_req        (imem_req),
		.imem_addr       (imem_addr),
		.imem_data       (imem_data),
		.imem_valid      (imem_valid),
		.space_ok        (space_ok),
		.out             (fetch_to_queue.producer)
	);

	fetch_queue u_fetch_queue
	(
		.clock    (clock),
		.reset    (reset),
		.in       (fetch_to_queue.consumer),
		.out      (queue_to_decode.producer),
		.space_ok (space_ok)
	);

	predecode_unit u_predecode_unit
	(
		.clock      (clock),
		.reset      (reset),
		.in         (queue_to_decode.consumer),
		.out_valid  (out_valid),
		.out_thread (out_thread),
		.out_pc     (out_pc),
		.out_inst   (out_inst),
		.out_class  (out_class),
		.out_ready  (out_ready)
	);

endmodule

// ==== tb/fetch_checker.sv ====
// Port-level assertions for fetch_top, attached with bind.
// Assumes the memory answers each request exactly one cycle later.

`include "fetch_config.svh"

module fetch_checker import fetch_types_pkg::*, isa_pkg::*;
(
	input logic                         clock,
	input logic                         reset,
	input logic                         imem_req,
	input logic                         imem_valid,
	input logic                         out_valid,
	input logic                         out_ready,
	input logic                         out_thread,
	input logic [`FETCH_ADDR_WIDTH-1:0] out_pc,
	input logic [`FETCH_INST_WIDTH-1:0] out_inst,
	input inst_class_e                  out_class,
	input thread_state_e                slot_state
);

	timeunit 1ns;
	timeprecision 100ps;

	// first cycle out of reset is idle
	reset_quiet_a: assert property (@(posedge clock)
		$fell(reset) |-> (!imem_req && !out_valid && (slot_state == PROGRAM_START)))
		else $error("fetch front end active in the first cycle after reset");

	// fixed memory latency
	mem_latency_a: assert property (@(posedge clock) disable iff (reset)
		imem_req |=> imem_valid)
		else $error("memory request not answered one cycle later");

	// decode port holds while stalled by decode
	out_hold_a: assert property (@(posedge clock) disable iff (reset)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_thread) && $stable(out_pc)
			&& $stable(out_inst) && $stable(out_class)))
		else $error("decode output changed while held");

endmodule

// ==== tb/fetch_tb.sv ====
// Testbench for the fetch front end.
// Memory model answers each request one cycle later with a word mixed
// from the address. Stops at the first mismatch.

`include "fetch_config.svh"

module fetch_tb import isa_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int AW    = `FETCH_ADDR_WIDTH;
	localparam int IW    = `FETCH_INST_WIDTH;
	localparam int DEPTH = `FETCH_QUEUE_DEPTH;

	logic          clock;
	logic          reset;
	logic          imem_req;
	logic [AW-1:0] imem_addr;
	logic [IW-1:0] imem_data;
	logic          imem_valid;
	logic          two_threads;
	logic [1:0]    thread_stall;
	logic          redirect_valid;
	logic          redirect_thread;
	logic [AW-1:0] redirect_pc;
	logic          out_valid;
	logic          out_thread;
	logic [AW-1:0] out_pc;
	logic [IW-1:0] out_inst;
	inst_class_e   out_class;
	logic          out_ready;

	integer        seed;
	logic          random_ready;          // out_ready follows random stretches
	int            ready_left;
	logic          forbid_thread [2];     // thread must not show up at the output
	int            redirect_issued [2];
	logic [AW-1:0] redirect_target [2];

	// scoreboard state
	logic [AW-1:0] exp_pc [2];
	int            redirect_taken [2];
	int            thread_count [2];
	int            total_count;
	int            held_cycles;
	int            full_hold_checks;      // cycles where a held output must block issue

	fetch_top u_dut (.*);

	bind fetch_top fetch_checker u_fetch_checker
	(
		.clock      (clock),
		.reset      (reset),
		.imem_req   (imem_req),
		.imem_valid (imem_valid),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_thread (out_thread),
		.out_pc     (out_pc),
		.out_inst   (out_inst),
		.out_class  (out_class),
		.slot_state (u_thread_pc_unit.state)
	);

	////////////////////////////////////////////////////////////////////////////
	// reference model

	function automatic logic [IW-1:0] mem_word(input logic [AW-1:0] addr);
		logic [31:0] mix;
		mix = (addr * 32'h9e37_79b1) ^ (addr >> 11) ^ 32'h5a5a_0f0f;
		return {addr[4:2], mix[IW-4:0]};  // opcode steps along sequential words
	endfunction

	function automatic inst_class_e expected_class(input logic [IW-1:0] inst);
		case (inst[IW-1 -: 3])
			OP_ALU, OP_ALU_IMM: expected_class = CLASS_COMPUTE;
			OP_LOAD, OP_STORE:  expected_class = CLASS_MEMORY;
			OP_BRANCH, OP_JUMP: expected_class = CLASS_CONTROL;
			default:            expected_class = CLASS_OTHER;  // system, nop
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s = 0x%08h, expected 0x%08h",
				$time, name, actual, expected);
			$display("Verification failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic report_timeout(input string what, input int limit);
		$display("timeout: no progress on %s within %0d cycles", what, limit);
		$display("Verification failed");
		$fatal(1, "stopped on timeout");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// clock and memory

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial
	begin
		logic          req_seen;
		logic [AW-1:0] addr_seen;
		imem_valid = 1'b0;
		imem_data  = '0;
		forever
		begin
			@(negedge clock);
			req_seen  = imem_req && !reset;
			addr_seen = imem_addr;
			@(posedge clock);
			#1;
			imem_valid = req_seen;
			imem_data  = req_seen ? mem_word(addr_seen) : '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// scoreboard

	task automatic score_output();
		logic t;
		t = out_thread;
		if (forbid_thread[t])
			check_value("out_thread", {31'd0, out_thread}, {31'd0, !out_thread});
		// switch to the new stream at the first target PC
		if (redirect_taken[t] != redirect_issued[t] && out_pc == redirect_target[t])
		begin
			exp_pc[t]         = redirect_target[t];
			redirect_taken[t] = redirect_issued[t];
		end
		check_value("out_pc", out_pc, exp_pc[t]);
		check_value("out_inst", out_inst, mem_word(out_pc));
		check_value("out_class", {30'd0, out_class}, {30'd0, expected_class(out_inst)});
		exp_pc[t] = exp_pc[t] + 32'd4;
		thread_count[t]++;
		total_count++;
	endtask

	initial
	begin
		exp_pc[0]         = `FETCH_RESET_PC0;
		exp_pc[1]         = `FETCH_RESET_PC1;
		redirect_taken[0] = 0;
		redirect_taken[1] = 0;
		thread_count[0]   = 0;
		thread_count[1]   = 0;
		total_count       = 0;
		held_cycles       = 0;
		full_hold_checks  = 0;
		forever
		begin
			@(negedge clock);  // outputs settled and inputs driven
			if (!reset)
			begin
				if (out_valid && out_ready)
					score_output();
				held_cycles = (out_valid && !out_ready) ? held_cycles + 1 : 0;
				if (held_cycles > DEPTH + 4)
				begin
					check_value("imem_req", {31'd0, imem_req}, 32'd0);  // queue full by now
					full_hold_checks++;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus

	task automatic advance_cycle();
		int r;
		@(posedge clock);
		#1;
		redirect_valid = 1'b0;  // one-cycle pulse
		if (!random_ready)
			out_ready = 1'b1;
		else
		begin
			if (ready_left == 0)
			begin
				r          = $random(seed);
				out_ready  = !out_ready;
				ready_left = out_ready ? 1 + (r & 7) : 4 + (r & 31);  // long low stretches
			end
			ready_left--;
		end
	endtask

	function automatic int seen_count(input logic any_thread, input logic t);
		return any_thread ? total_count : thread_count[t];
	endfunction

	task automatic wait_outputs(input logic any_thread, input logic t, input int n,
		input string what);
		int start;
		int cycles;
		int limit;
		start  = seen_count(any_thread, t);
		limit  = 40 * n + 400;
		cycles = 0;
		while (seen_count(any_thread, t) - start < n && cycles < limit)
		begin
			advance_cycle();
			cycles++;
		end
		if (seen_count(any_thread, t) - start < n)
			report_timeout(what, limit);
	endtask

	task automatic send_redirect(input logic t, input logic [AW-1:0] target);
		int cycles;
		redirect_target[t] = target;
		redirect_issued[t]++;
		redirect_thread    = t;
		redirect_pc        = target;
		redirect_valid     = 1'b1;
		cycles             = 0;
		while (redirect_taken[t] != redirect_issued[t] && cycles < 400)
		begin
			advance_cycle();
			cycles++;
		end
		if (redirect_taken[t] != redirect_issued[t])
			report_timeout("redirected stream", 400);
	endtask

	task automatic stall_phase(input logic s);
		thread_stall[s] = 1'b1;
		wait_outputs(1'b1, 1'b0, DEPTH + 3, "drain after stall");  // entries in flight
		forbid_thread[s] = 1'b1;
		wait_outputs(1'b0, !s, 30, "other thread while one is stalled");
		forbid_thread[s] = 1'b0;
		thread_stall[s]  = 1'b0;
		wait_outputs(1'b0, s, 10, "stalled thread resuming");
	endtask

	initial
	begin
		int            r;
		logic          t;
		logic [AW-1:0] target;

		seed               = 82;
		reset              = 1'b1;
		two_threads        = 1'b0;
		thread_stall       = 2'b00;
		redirect_valid     = 1'b0;
		redirect_thread    = 1'b0;
		redirect_pc        = '0;
		out_ready          = 1'b0;
		random_ready       = 1'b0;
		ready_left         = 0;
		forbid_thread[0]   = 1'b0;
		forbid_thread[1]   = 1'b1;  // single-thread mode first
		redirect_issued[0] = 0;
		redirect_issued[1] = 0;
		redirect_target[0] = '0;
		redirect_target[1] = '0;

		repeat (8) advance_cycle();
		reset = 1'b0;

		wait_outputs(1'b1, 1'b0, 40, "single-thread outputs");

		two_threads      = 1'b1;
		forbid_thread[1] = 1'b0;
		wait_outputs(1'b0, 1'b1, 40, "thread 1 outputs in two-thread mode");
		wait_outputs(1'b0, 1'b0, 20, "thread 0 outputs in two-thread mode");

		stall_phase(1'b1);
		stall_phase(1'b0);

		// redirects at random gaps with each target in its own window
		repeat (6)
		begin
			r = $random(seed);
			repeat (r & 15) advance_cycle();
			t      = r[4];
			target = 32'h0010_0000 | {15'd0, t, 16'd0}
				| (32'(redirect_issued[t] + 1) << 12) | (32'(r[12:5]) << 2);
			send_redirect(t, target);
		end

		////////////////////////////////////////////////////////////////////////
		// back-pressure

		random_ready = 1'b1;
		wait_outputs(1'b1, 1'b0, 100, "outputs under back-pressure");
		repeat (8)
		begin
			r            = $random(seed);
			thread_stall = (r[1:0] == 2'b11) ? 2'b00 : r[1:0];
			wait_outputs(1'b1, 1'b0, 20, "outputs with random stalls");
		end
		thread_stall = 2'b00;
		two_threads  = 1'b0;
		wait_outputs(1'b1, 1'b0, DEPTH + 3, "drain after leaving two-thread mode");
		forbid_thread[1] = 1'b1;
		wait_outputs(1'b0, 1'b0, 60, "single-thread outputs under back-pressure");

		if (full_hold_checks > 0)
		begin
			$display("Verification passed");
			$finish;
		end
		else
		begin
			$display("queue never filled while decode held the output");
			$display("Verification failed");
			$fatal(1, "end of test");
		end
	end

endmodule

// ==== compile.f ====
+incdir+logic
logic/fetch_types_pkg.sv
logic/isa_pkg.sv
logic/fetch_bus_if.sv
logic/thread_pc_unit.sv
logic/fetch_queue.sv
logic/predecode_unit.sv
logic/fetch_top.sv
tb/fetch_checker.sv
tb/fetch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the fetch front end testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

if ! verilator --binary --timing --assert -f compile.f --top-module fetch_tb \
	-Mdir obj_dir -o fetch_sim > "$build_log" 2>&1; then
	cat "$build_log"
	echo "build failed, see $build_log"
	exit 1
fi

./obj_dir/fetch_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "Verification failed" "$sim_log"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
echo "simulation finished without failures"
exit 0
